// ==== logic/mips_pkg.sv ====
package mips_pkg;

	// **************************************************
	// Decoded instruction classes and datapath selects
	// **************************************************

	typedef enum logic [3:0] {
		kind_nop,
		kind_addu,
		kind_subu,
		kind_and,
		kind_or,
		kind_slt,
		kind_addiu,
		kind_ori,
		kind_lui,
		kind_lw,
		kind_sw,
		kind_beq,
		kind_bne,
		kind_j,
		kind_jal
	} instr_kind_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_load,
		wb_link
	} wb_sel_e;

	// **************************************************
	// MIPS32 encodings of the supported subset
	// **************************************************

	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_jal     = 6'h03;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_lui     = 6'h0f;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

endpackage

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          stall,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
	input  logic [31:0]                   imem_wdata,
	input  logic                          branch_taken,
	input  logic [31:0]                   branch_target,
	input  logic                          jump_taken,
	input  logic [31:0]                   jump_target,
	output logic [31:0]                   if_pc,
	output logic [31:0]                   if_instr
);

	localparam int IMEM_AW = $clog2(IMEM_WORDS);

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] next_pc;
	logic [31:0] fetch_instr;

	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata; // Loaded only while run is low.
		end
	end

	assign fetch_instr = imem[pc[IMEM_AW+1:2]];

	assign next_pc = jump_taken ? jump_target :
		branch_taken ? branch_target :
		pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= 32'd0;
		end else if (run && !stall) begin
			pc <= next_pc;
		end
	end

	// Fetch/decode register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_pc    <= 32'd0;
			if_instr <= 32'd0;
		end else if (!run) begin
			if_pc    <= 32'd0;
			if_instr <= 32'd0; // A zero word decodes as a nop.
		end else if (!stall) begin
			if_pc    <= pc;
			if_instr <= fetch_instr;
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic [31:0]           if_pc,
	input  logic [31:0]           if_instr,
	input  logic                  wb_write,
	input  logic [4:0]            wb_dest,
	input  logic [31:0]           wb_data,
	input  mips_pkg::fwd_sel_e    fwd_d_rs,
	input  mips_pkg::fwd_sel_e    fwd_d_rt,
	input  logic [31:0]           ex_result,
	output logic [4:0]            id_rs,
	output logic [4:0]            id_rt,
	output logic                  id_rs_branch,
	output logic                  id_rt_branch,
	output logic                  id_rs_exec,
	output logic                  id_rt_exec,
	output logic                  branch_taken,
	output logic [31:0]           branch_target,
	output logic                  jump_taken,
	output logic [31:0]           jump_target,
	output mips_pkg::instr_kind_e id_kind,
	output mips_pkg::alu_op_e     id_alu_op,
	output mips_pkg::wb_sel_e     id_wb_sel,
	output logic                  id_use_imm,
	output logic [31:0]           id_rs_val,
	output logic [31:0]           id_rt_val,
	output logic [31:0]           id_imm,
	output logic [4:0]            id_dest,
	output logic [31:0]           id_pc,
	output logic [4:0]            exe_rs,
	output logic [4:0]            exe_rt,
	output logic                  exe_is_load
);

	import mips_pkg::*;

	logic [31:0] regs [32];
	logic [5:0]  opcode;
	logic [5:0]  funct;
	instr_kind_e kind;
	alu_op_e     alu_op;
	wb_sel_e     wb_sel;
	logic        use_imm;
	logic [4:0]  dest;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] imm_ext;
	logic [31:0] delay_pc;

	assign opcode = if_instr[31:26];
	assign funct  = if_instr[5:0];
	assign id_rs  = if_instr[25:21];
	assign id_rt  = if_instr[20:16];

	always_comb begin
		case (opcode)
			op_special: begin
				case (funct)
					fn_addu: kind = kind_addu;
					fn_subu: kind = kind_subu;
					fn_and:  kind = kind_and;
					fn_or:   kind = kind_or;
					fn_slt:  kind = kind_slt;
					default: kind = kind_nop; // Includes sll $0,$0,0.
				endcase
			end
			op_addiu: kind = kind_addiu;
			op_ori:   kind = kind_ori;
			op_lui:   kind = kind_lui;
			op_lw:    kind = kind_lw;
			op_sw:    kind = kind_sw;
			op_beq:   kind = kind_beq;
			op_bne:   kind = kind_bne;
			op_j:     kind = kind_j;
			op_jal:   kind = kind_jal;
			default:  kind = kind_nop;
		endcase
	end

	always_comb begin
		dest         = 5'd0;
		wb_sel       = wb_alu;
		use_imm      = 1'b0;
		id_rs_exec   = 1'b0;
		id_rt_exec   = 1'b0;
		id_rs_branch = 1'b0;
		id_rt_branch = 1'b0;
		case (kind)
			kind_addu, kind_subu, kind_and, kind_or, kind_slt: begin
				dest       = if_instr[15:11];
				id_rs_exec = 1'b1;
				id_rt_exec = 1'b1;
			end
			kind_addiu, kind_ori, kind_lui, kind_lw: begin
				dest       = id_rt;
				use_imm    = 1'b1;
				id_rs_exec = (kind != kind_lui);
				wb_sel     = (kind == kind_lw) ? wb_load : wb_alu;
			end
			kind_sw: begin
				use_imm    = 1'b1;
				id_rs_exec = 1'b1; // Store data is needed only in the memory stage.
			end
			kind_beq, kind_bne: begin
				id_rs_branch = 1'b1;
				id_rt_branch = 1'b1;
			end
			kind_jal: begin
				dest   = 5'd31;
				wb_sel = wb_link;
			end
			default: begin
				dest = 5'd0;
			end
		endcase
	end

	always_comb begin
		case (kind)
			kind_subu:         alu_op = alu_sub;
			kind_and:          alu_op = alu_and;
			kind_or, kind_ori: alu_op = alu_or;
			kind_slt:          alu_op = alu_slt;
			kind_lui:          alu_op = alu_lui;
			default:           alu_op = alu_add;
		endcase
	end

	// **************************************************
	// Register file
	// **************************************************

	function automatic logic [31:0] read_reg(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return 32'd0;
		end
		if (wb_write && (wb_dest == addr)) begin
			return wb_data; // Write-through from writeback.
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wb_write && (wb_dest != 5'd0)) begin
			regs[wb_dest] <= wb_data;
		end
	end

	assign rs_val = (fwd_d_rs == fwd_mem) ? ex_result : read_reg(id_rs);
	assign rt_val = (fwd_d_rt == fwd_mem) ? ex_result : read_reg(id_rt);

	assign imm_ext  = (kind == kind_ori) ? {16'h0, if_instr[15:0]} :
		{{16{if_instr[15]}}, if_instr[15:0]};
	assign delay_pc = if_pc + 32'd4;

	assign branch_target = delay_pc + {imm_ext[29:0], 2'b00};
	assign jump_target   = {delay_pc[31:28], if_instr[25:0], 2'b00};
	assign branch_taken  = ((kind == kind_beq) && (rs_val == rt_val)) ||
		((kind == kind_bne) && (rs_val != rt_val));
	assign jump_taken    = (kind == kind_j) || (kind == kind_jal);

	// **************************************************
	// Decode/execute register
	// **************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_kind    <= kind_nop;
			id_alu_op  <= alu_add;
			id_wb_sel  <= wb_alu;
			id_use_imm <= 1'b0;
			id_dest    <= 5'd0;
			exe_rs     <= 5'd0;
			exe_rt     <= 5'd0;
		end else begin
			id_kind    <= stall ? kind_nop : kind; // A stall inserts a bubble.
			id_alu_op  <= alu_op;
			id_wb_sel  <= wb_sel;
			id_use_imm <= use_imm;
			id_dest    <= stall ? 5'd0 : dest;
			exe_rs     <= stall ? 5'd0 : id_rs;
			exe_rt     <= stall ? 5'd0 : id_rt;
		end
	end

	always_ff @(posedge clk) begin
		id_rs_val <= rs_val;
		id_rt_val <= rt_val;
		id_imm    <= imm_ext;
		id_pc     <= if_pc;
	end

	assign exe_is_load = (id_kind == kind_lw);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mips_pkg::instr_kind_e id_kind,
	input  mips_pkg::alu_op_e     id_alu_op,
	input  mips_pkg::wb_sel_e     id_wb_sel,
	input  logic                  id_use_imm,
	input  logic [31:0]           id_rs_val,
	input  logic [31:0]           id_rt_val,
	input  logic [31:0]           id_imm,
	input  logic [4:0]            id_dest,
	input  logic [31:0]           id_pc,
	input  logic [4:0]            exe_rt,
	input  mips_pkg::fwd_sel_e    fwd_e_rs,
	input  mips_pkg::fwd_sel_e    fwd_e_rt,
	input  logic [31:0]           mem_fwd_data,
	input  logic [31:0]           wb_data,
	output logic [31:0]           ex_result,
	output logic [31:0]           ex_store_data,
	output logic [4:0]            ex_dest,
	output logic                  ex_is_load,
	output logic                  ex_is_store,
	output mips_pkg::wb_sel_e     ex_wb_sel,
	output logic [4:0]            ex_rt
);

	import mips_pkg::*;

	logic [31:0] op_a;
	logic [31:0] rt_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] result;

	function automatic logic [31:0] pick(input fwd_sel_e sel, input logic [31:0] reg_val,
		input logic [31:0] mem_val, input logic [31:0] wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a   = pick(fwd_e_rs, id_rs_val, mem_fwd_data, wb_data);
	assign rt_fwd = pick(fwd_e_rt, id_rt_val, mem_fwd_data, wb_data);
	assign op_b   = id_use_imm ? id_imm : rt_fwd;

	always_comb begin
		case (id_alu_op)
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_lui: alu_out = {op_b[15:0], 16'h0};
			default: alu_out = op_a + op_b;
		endcase
	end

	assign result = (id_wb_sel == wb_link) ? id_pc + 32'd8 : alu_out; // Skips the delay slot.

	// Execute/memory register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_dest     <= 5'd0;
			ex_is_load  <= 1'b0;
			ex_is_store <= 1'b0;
			ex_wb_sel   <= wb_alu;
			ex_rt       <= 5'd0;
		end else begin
			ex_dest     <= id_dest;
			ex_is_load  <= (id_kind == kind_lw);
			ex_is_store <= (id_kind == kind_sw);
			ex_wb_sel   <= id_wb_sel;
			ex_rt       <= (id_kind == kind_sw) ? exe_rt : 5'd0;
		end
	end

	always_ff @(posedge clk) begin
		ex_result     <= result;
		ex_store_data <= rt_fwd;
	end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [31:0]       ex_result,
	input  logic [31:0]       ex_store_data,
	input  logic [4:0]        ex_dest,
	input  logic              ex_is_load,
	input  logic              ex_is_store,
	input  mips_pkg::wb_sel_e ex_wb_sel,
	input  mips_pkg::fwd_sel_e fwd_m_store,
	output logic [31:0]       mem_fwd_data,
	output logic              wb_write,
	output logic [4:0]        wb_dest,
	output logic [31:0]       wb_data,
	output logic              wb_valid,
	output logic [4:0]        wb_reg,
	output logic              st_valid,
	output logic [31:0]       st_addr,
	output logic [31:0]       st_wdata
);

	import mips_pkg::*;

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	logic [31:0]        dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_idx;
	logic [31:0]        store_data;
	wb_sel_e            wb_sel;
	logic [31:0]        wb_result;
	logic [31:0]        wb_load_data;

	assign dmem_idx     = ex_result[DMEM_AW+1:2]; // Word index, wraps at DMEM_WORDS.
	assign store_data   = (fwd_m_store == fwd_wb) ? wb_data : ex_store_data;
	assign mem_fwd_data = ex_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= 32'd0;
			end
		end else if (ex_is_store) begin
			dmem[dmem_idx] <= store_data;
		end
	end

	// Memory/writeback register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_write <= 1'b0;
			wb_dest  <= 5'd0;
			wb_sel   <= wb_alu;
		end else begin
			wb_write <= (ex_dest != 5'd0);
			wb_dest  <= ex_dest;
			wb_sel   <= ex_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		wb_result <= ex_result;
		if (ex_is_load) begin
			wb_load_data <= dmem[dmem_idx];
		end
	end

	assign wb_data = (wb_sel == wb_load) ? wb_load_data : wb_result;

	// Trace ports.
	assign wb_valid = wb_write;
	assign wb_reg   = wb_dest;
	assign st_valid = ex_is_store;
	assign st_addr  = ex_result;
	assign st_wdata = store_data;

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
	input  logic               [4:0] id_rs,
	input  logic               [4:0] id_rt,
	input  logic                     id_rs_branch,
	input  logic                     id_rt_branch,
	input  logic                     id_rs_exec,
	input  logic                     id_rt_exec,
	input  logic               [4:0] exe_rs,
	input  logic               [4:0] exe_rt,
	input  logic               [4:0] exe_dest,
	input  logic                     exe_is_load,
	input  logic               [4:0] ex_dest,
	input  logic                     ex_is_load,
	input  logic               [4:0] ex_rt,
	input  logic               [4:0] wb_dest,
	output logic                     stall,
	output mips_pkg::fwd_sel_e       fwd_d_rs,
	output mips_pkg::fwd_sel_e       fwd_d_rt,
	output mips_pkg::fwd_sel_e       fwd_e_rs,
	output mips_pkg::fwd_sel_e       fwd_e_rt,
	output mips_pkg::fwd_sel_e       fwd_m_store
);

	import mips_pkg::*;

	// **************************************************
	// Source checks against the instructions ahead
	// **************************************************

	function automatic logic src_stall(input logic [4:0] src, input logic use_branch,
		input logic use_exec);
		logic hit_exe;
		logic hit_mem;
		hit_exe = (src != 5'd0) && (src == exe_dest);
		hit_mem = (src != 5'd0) && (src == ex_dest);
		return (hit_exe && exe_is_load && use_exec) ||
			(hit_exe && use_branch) ||
			(hit_mem && ex_is_load && use_branch);
	endfunction

	// Loads in memory still hold their address, so they never forward.
	function automatic fwd_sel_e decode_fwd(input logic [4:0] src, input logic use_branch);
		if (use_branch && (src != 5'd0) && (src == ex_dest) && !ex_is_load) begin
			return fwd_mem;
		end
		return fwd_none;
	endfunction

	function automatic fwd_sel_e exe_fwd(input logic [4:0] src);
		if ((src != 5'd0) && (src == ex_dest) && !ex_is_load) begin
			return fwd_mem; // The newer producer wins.
		end
		if ((src != 5'd0) && (src == wb_dest)) begin
			return fwd_wb;
		end
		return fwd_none;
	endfunction

	always_comb begin
		stall       = src_stall(id_rs, id_rs_branch, id_rs_exec) ||
			src_stall(id_rt, id_rt_branch, id_rt_exec);
		fwd_d_rs    = decode_fwd(id_rs, id_rs_branch);
		fwd_d_rt    = decode_fwd(id_rt, id_rt_branch);
		fwd_e_rs    = exe_fwd(exe_rs);
		fwd_e_rt    = exe_fwd(exe_rt);
		fwd_m_store = ((ex_rt != 5'd0) && (ex_rt == wb_dest)) ? fwd_wb : fwd_none;
	end

endmodule

// ==== logic/mips_core.sv ====
`timescale 1ns/10ps

module mips_core #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
	input  logic [31:0]                   imem_wdata,
	output logic                          wb_valid,
	output logic [4:0]                    wb_reg,
	output logic [31:0]                   wb_data,
	output logic                          st_valid,
	output logic [31:0]                   st_addr,
	output logic [31:0]                   st_wdata
);

	import mips_pkg::*;

	logic        stall;
	logic [31:0] if_pc;
	logic [31:0] if_instr;
	logic        branch_taken;
	logic [31:0] branch_target;
	logic        jump_taken;
	logic [31:0] jump_target;

	logic [4:0]  id_rs;
	logic [4:0]  id_rt;
	logic        id_rs_branch;
	logic        id_rt_branch;
	logic        id_rs_exec;
	logic        id_rt_exec;
	instr_kind_e id_kind;
	alu_op_e     id_alu_op;
	wb_sel_e     id_wb_sel;
	logic        id_use_imm;
	logic [31:0] id_rs_val;
	logic [31:0] id_rt_val;
	logic [31:0] id_imm;
	logic [4:0]  id_dest;
	logic [31:0] id_pc;
	logic [4:0]  exe_rs;
	logic [4:0]  exe_rt;
	logic        exe_is_load;

	logic [31:0] ex_result;
	logic [31:0] ex_store_data;
	logic [4:0]  ex_dest;
	logic        ex_is_load;
	logic        ex_is_store;
	wb_sel_e     ex_wb_sel;
	logic [4:0]  ex_rt;

	logic [31:0] mem_fwd_data;
	logic        wb_write;
	logic [4:0]  wb_dest;

	fwd_sel_e    fwd_d_rs;
	fwd_sel_e    fwd_d_rt;
	fwd_sel_e    fwd_e_rs;
	fwd_sel_e    fwd_e_rt;
	fwd_sel_e    fwd_m_store;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch_stage (.*);

	decode_stage i_decode_stage (.*);

	execute_stage i_execute_stage (.*);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) i_memory_stage (.*);

	hazard_unit i_hazard_unit (
		.exe_dest(id_dest),
		.*
	);

endmodule

// ==== verification/mips_model.svh ====
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// **************************************************
// Program image, reference state and expected events
// **************************************************

logic [31:0] prog [PROG_WORDS];
logic [31:0] model_regs [32];
logic [31:0] model_mem [DMEM_WORDS];
logic [4:0]  exp_reg_q [$];
logic [31:0] exp_val_q [$];
logic [31:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];

function automatic int rand_below(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [4:0] rand_reg();
	return 5'(rand_below(8)); // Only $0 to $7 so that dependencies are dense.
endfunction

function automatic logic [15:0] word_offset();
	return 16'(rand_below(DMEM_WORDS) * 4);
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input logic [5:0] fn);
	return {op_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
	return {op, idx};
endfunction

function automatic logic [31:0] rand_alu();
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;
	rs  = rand_reg();
	rt  = rand_reg();
	rd  = rand_reg();
	imm = 16'($random(seed));
	case (rand_below(8))
		0: return enc_r(rs, rt, rd, fn_addu);
		1: return enc_r(rs, rt, rd, fn_subu);
		2: return enc_r(rs, rt, rd, fn_and);
		3: return enc_r(rs, rt, rd, fn_or);
		4: return enc_r(rs, rt, rd, fn_slt);
		5: return enc_i(op_addiu, rs, rt, imm);
		6: return enc_i(op_ori, rs, rt, imm);
		default: return enc_i(op_lui, 5'd0, rt, imm);
	endcase
endfunction

function automatic logic [31:0] rand_transfer(input int at, input int tgt);
	logic [15:0] off;
	off = 16'(tgt - at - 1); // Counted in words from the delay slot.
	case (rand_below(4))
		0: return enc_i(op_beq, rand_reg(), rand_reg(), off);
		1: return enc_i(op_bne, rand_reg(), rand_reg(), off);
		2: return enc_j(op_j, 26'(tgt));
		default: return enc_j(op_jal, 26'(tgt));
	endcase
endfunction

function automatic void gen_program();
	int i;
	int tgt;
	i = 0;
	while (i < HALT_IDX) begin
		case (rand_below(10))
			6: prog[i] = enc_i(op_lw, 5'd0, rand_reg(), word_offset());
			7: prog[i] = enc_i(op_sw, 5'd0, rand_reg(), word_offset());
			8, 9: begin
				if (i + 1 < HALT_IDX) begin
					tgt         = i + 2 + rand_below(HALT_IDX - i - 1); // Forward only.
					prog[i]     = rand_transfer(i, tgt);
					prog[i + 1] = rand_alu();
					i++;
				end else begin
					prog[i] = rand_alu();
				end
			end
			default: prog[i] = rand_alu();
		endcase
		i++;
	end
	prog[HALT_IDX]     = enc_i(op_beq, 5'd0, 5'd0, 16'hffff); // Branches to itself.
	prog[HALT_IDX + 1] = 32'd0;
endfunction

// **************************************************
// Instruction-set model in program order
// **************************************************

function automatic void write_reg(input logic [4:0] r, input logic [31:0] v);
	if (r != 5'd0) begin
		model_regs[r] = v;
		exp_reg_q.push_back(r);
		exp_val_q.push_back(v);
	end
endfunction

function automatic void run_model();
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] nnpc;
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] addr;
	int          k;
	int          steps;
	exp_reg_q.delete();
	exp_val_q.delete();
	exp_addr_q.delete();
	exp_data_q.delete();
	for (k = 0; k < 32; k++) begin
		model_regs[k] = 32'd0;
	end
	for (k = 0; k < DMEM_WORDS; k++) begin
		model_mem[k] = 32'd0;
	end
	pc    = 32'd0;
	npc   = 32'd4;
	steps = 0;
	while ((pc != HALT_PC) && (steps < 4 * PROG_WORDS)) begin
		instr = prog[pc[7:2]];
		a     = model_regs[instr[25:21]];
		b     = model_regs[instr[20:16]];
		simm  = {{16{instr[15]}}, instr[15:0]};
		nnpc  = npc + 32'd4;
		case (instr[31:26])
			op_special: begin
				case (instr[5:0])
					fn_addu: write_reg(instr[15:11], a + b);
					fn_subu: write_reg(instr[15:11], a - b);
					fn_and:  write_reg(instr[15:11], a & b);
					fn_or:   write_reg(instr[15:11], a | b);
					fn_slt:  write_reg(instr[15:11], {31'd0, $signed(a) < $signed(b)});
					default: ;
				endcase
			end
			op_addiu: write_reg(instr[20:16], a + simm);
			op_ori:   write_reg(instr[20:16], a | {16'h0, instr[15:0]});
			op_lui:   write_reg(instr[20:16], {instr[15:0], 16'h0});
			op_lw: begin
				addr = a + simm;
				write_reg(instr[20:16], model_mem[addr[DMEM_AW+1:2]]);
			end
			op_sw: begin
				addr = a + simm;
				model_mem[addr[DMEM_AW+1:2]] = b;
				exp_addr_q.push_back(addr);
				exp_data_q.push_back(b);
			end
			op_beq: if (a == b) nnpc = npc + {simm[29:0], 2'b00};
			op_bne: if (a != b) nnpc = npc + {simm[29:0], 2'b00};
			op_j:   nnpc = {npc[31:28], instr[25:0], 2'b00};
			op_jal: begin
				write_reg(5'd31, pc + 32'd8); // Return lands after the delay slot.
				nnpc = {npc[31:28], instr[25:0], 2'b00};
			end
			default: ;
		endcase
		pc    = npc;
		npc   = nnpc;
		steps = steps + 1;
	end
endfunction

`endif

// ==== verification/mips_tb.sv ====
`timescale 1ns/10ps

module mips_tb;

	import mips_pkg::*;

	localparam int          IMEM_WORDS = 256;
	localparam int          DMEM_WORDS = 64;
	localparam int          DMEM_AW    = $clog2(DMEM_WORDS);
	localparam int          PROG_WORDS = 64;
	localparam int          HALT_IDX   = PROG_WORDS - 2;
	localparam logic [31:0] HALT_PC    = 32'(HALT_IDX * 4);
	localparam int          NUM_PROGS  = 24;

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        imem_we;
	logic [7:0]  imem_addr;
	logic [31:0] imem_wdata;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        st_valid;
	logic [31:0] st_addr;
	logic [31:0] st_wdata;
	integer      seed;
	int          prog_idx;

	`include "mips_model.svh"

	mips_core #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) i_mips_core (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %08h, actual %08h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Simulation stopped.");
		end
	endtask

	// **************************************************
	// Trace monitor
	// **************************************************

	always @(negedge clk) begin
		if (!run && (wb_valid || st_valid)) begin
			abort_run("Trace output went active while run was low.");
		end
		if (run && wb_valid) begin
			if (exp_reg_q.size() == 0) begin
				abort_run($sformatf("Unexpected write of %08h to register %0d in program %0d.",
					wb_data, wb_reg, prog_idx));
			end else begin
				check_value($sformatf("prog%0d wb_reg", prog_idx),
					{27'd0, exp_reg_q.pop_front()}, {27'd0, wb_reg});
				check_value($sformatf("prog%0d wb_data", prog_idx), exp_val_q.pop_front(), wb_data);
			end
		end
		if (run && st_valid) begin
			if (exp_addr_q.size() == 0) begin
				abort_run($sformatf("Unexpected store of %08h to address %08h in program %0d.",
					st_wdata, st_addr, prog_idx));
			end else begin
				check_value($sformatf("prog%0d st_addr", prog_idx), exp_addr_q.pop_front(), st_addr);
				check_value($sformatf("prog%0d st_wdata", prog_idx), exp_data_q.pop_front(), st_wdata);
			end
		end
	end

	task automatic run_program();
		int n_wr;
		int n_st;
		n_wr = exp_reg_q.size();
		n_st = exp_addr_q.size();
		@(posedge clk);
		#2;
		run   = 1'b0;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem_we    = 1'b1;
			imem_addr  = 8'(i);
			imem_wdata = prog[i];
			@(posedge clk);
			#2;
		end
		imem_we = 1'b0;
		run     = 1'b1;
		do begin
			@(negedge clk);
		end while (i_mips_core.if_pc !== HALT_PC); // Halt branch is in decode.
		repeat (4) @(posedge clk); // Older instructions leave writeback.
		if ((exp_reg_q.size() != 0) || (exp_addr_q.size() != 0)) begin
			abort_run($sformatf("Program %0d halted with %0d writes and %0d stores missing.",
				prog_idx, exp_reg_q.size(), exp_addr_q.size()));
		end
		$display("Program %0d finished: %0d writes, %0d stores.", prog_idx, n_wr, n_st);
	endtask

	initial begin
		seed       = 32'h55f1d87b;
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = 8'd0;
		imem_wdata = 32'd0;
		prog_idx   = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			prog_idx = p;
			gen_program();
			run_model();
			run_program();
		end
		$display("TEST OK");
		$finish;
	end

	initial begin
		repeat (NUM_PROGS * PROG_WORDS * 3 + 100) @(posedge clk);
		abort_run("Timeout: the DUT did not reach the halt loop in time.");
	end

endmodule

// ==== compile.f ====
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/mips_core.sv
+incdir+verification
verification/mips_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = mips_tb
FILELIST  = compile.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
